/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN        = 32;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = 2;

    // base opcodes handled by the main decoder
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_src_t;

    typedef enum logic [1:0] {
        ALUOP_ADD    = 2'd0,
        ALUOP_BRANCH = 2'd1,
        ALUOP_FUNCT  = 2'd2,
        ALUOP_PASSB  = 2'd3
    } alu_op_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_PASSB = 3'd4,
        ALU_SLT   = 3'd5
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    // opcode, rd, funct3, rs1 and rs2 sit at the same bits in every view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

/* source/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           instr_valid_i,
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    input  logic                           full_i,
    output logic                           push_o,
    output logic [rv_decode_pkg::XLEN-1:0] push_pc_o,
    output logic [rv_decode_pkg::XLEN-1:0] push_instr_o,
    output logic [rv_decode_pkg::XLEN-1:0] fetch_pc_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] pc_q;

    // a strobe against a full queue is dropped
    assign push_o       = instr_valid_i & ~full_i;
    assign push_pc_o    = pc_q;
    assign push_instr_o = instr_i;
    assign fetch_pc_o   = pc_q; // address of the next expected word

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (push_o) begin
            pc_q <= pc_q + XLEN'(4); // no redirection, sequential only
        end
    end

endmodule

/* source/instr_queue.sv */
`timescale 1ns/1ns

module instr_queue (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           push_i,
    input  logic [rv_decode_pkg::XLEN-1:0] push_pc_i,
    input  logic [rv_decode_pkg::XLEN-1:0] push_instr_i,
    input  logic                           pop_i,
    output logic [rv_decode_pkg::XLEN-1:0] pop_pc_o,
    output logic [rv_decode_pkg::XLEN-1:0] pop_instr_o,
    output logic                           full_o,
    output logic                           empty_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] pc_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0] instr_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QPTR_W:0]   count_q;
    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == (QPTR_W+1)'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);

    // full queue still takes a push when the head leaves in the same cycle
    assign do_push = push_i & (~full_o | pop_i);
    assign do_pop  = pop_i & ~empty_o;

    assign pop_pc_o    = pc_mem[rd_ptr_q];
    assign pop_instr_o = instr_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]    <= push_pc_i;
            instr_mem[wr_ptr_q] <= push_instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // idle, or push and pop together
            endcase
        end
    end

endmodule

/* source/main_decoder.sv */
`timescale 1ns/1ns

module main_decoder (
    input  logic [6:0]                 op_i,
    output logic                       branch_o,
    output logic                       jump_o,
    output rv_decode_pkg::result_src_t result_src_o,
    output logic                       mem_write_o,
    output logic                       alu_src_o,
    output rv_decode_pkg::imm_src_t    imm_src_o,
    output logic                       reg_write_o,
    output rv_decode_pkg::alu_op_t     alu_op_o
);

    import rv_decode_pkg::*;

    always_comb begin
        // register operation values, also taken by unknown opcodes
        reg_write_o  = 1'b1;
        imm_src_o    = IMM_I; // unused by register ops
        alu_src_o    = 1'b0;
        mem_write_o  = 1'b0;
        result_src_o = RES_ALU;
        branch_o     = 1'b0;
        alu_op_o     = ALUOP_FUNCT;
        jump_o       = 1'b0;

        case (op_i)
            OP_LOAD: begin
                alu_src_o    = 1'b1;
                result_src_o = RES_MEM;
                alu_op_o     = ALUOP_ADD; // base plus offset
            end
            OP_STORE: begin
                reg_write_o = 1'b0;
                imm_src_o   = IMM_S;
                alu_src_o   = 1'b1;
                mem_write_o = 1'b1;
                alu_op_o    = ALUOP_ADD;
            end
            OP_BRANCH: begin
                reg_write_o = 1'b0;
                imm_src_o   = IMM_B;
                branch_o    = 1'b1;
                alu_op_o    = ALUOP_BRANCH; // compare by subtraction
            end
            OP_IMM: begin
                alu_src_o = 1'b1;
            end
            OP_JAL: begin
                imm_src_o    = IMM_J;
                result_src_o = RES_PC4; // link address
                alu_op_o     = ALUOP_ADD;
                jump_o       = 1'b1;
            end
            OP_LUI: begin
                imm_src_o = IMM_U;
                alu_src_o = 1'b1;
                alu_op_o  = ALUOP_PASSB;
            end
            default: begin
                // OP_REG and anything unrecognised keep the values above
            end
        endcase
    end

endmodule

/* source/alu_decoder.sv */
`timescale 1ns/1ns

module alu_decoder (
    input  rv_decode_pkg::alu_op_t   alu_op_i,
    input  logic [2:0]               funct3_i,
    input  logic                     funct7b5_i,
    input  logic                     op_b5_i,
    output rv_decode_pkg::alu_ctrl_t alu_ctrl_o
);

    import rv_decode_pkg::*;

    always_comb begin
        case (alu_op_i)
            ALUOP_ADD:    alu_ctrl_o = ALU_ADD;
            ALUOP_BRANCH: alu_ctrl_o = ALU_SUB;
            ALUOP_PASSB:  alu_ctrl_o = ALU_PASSB;
            default: begin
                case (funct3_i)
                    3'b000: begin
                        // sub only for register form, addi never subtracts
                        if (funct7b5_i && op_b5_i) begin
                            alu_ctrl_o = ALU_SUB;
                        end else begin
                            alu_ctrl_o = ALU_ADD;
                        end
                    end
                    3'b010:  alu_ctrl_o = ALU_SLT;
                    3'b110:  alu_ctrl_o = ALU_OR;
                    3'b111:  alu_ctrl_o = ALU_AND;
                    default: alu_ctrl_o = ALU_ADD; // unsupported funct3
                endcase
            end
        endcase
    end

endmodule

/* source/imm_extend.sv */
`timescale 1ns/1ns

module imm_extend (
    input  rv_decode_pkg::instr_u          instr_i,
    input  rv_decode_pkg::imm_src_t        imm_src_i,
    output logic [rv_decode_pkg::XLEN-1:0] imm_ext_o
);

    import rv_decode_pkg::*;

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_ext_o = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
            IMM_S: imm_ext_o = {{20{instr_i.s_fmt.imm_11_5[6]}}, instr_i.s_fmt.imm_11_5,
                                instr_i.s_fmt.imm_4_0};
            IMM_B: imm_ext_o = {{19{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
                                instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5,
                                instr_i.b_fmt.imm_4_1, 1'b0}; // halfword aligned
            IMM_J: imm_ext_o = {{11{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
                                instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11,
                                instr_i.j_fmt.imm_10_1, 1'b0};
            IMM_U: imm_ext_o = {instr_i.u_fmt.imm_31_12, 12'b0};
            default: imm_ext_o = '0;
        endcase
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           empty_i,
    input  logic [rv_decode_pkg::XLEN-1:0] pop_pc_i,
    input  logic [rv_decode_pkg::XLEN-1:0] pop_instr_i,
    input  logic                           hold_i,
    output logic                           pop_o,
    output logic                           dec_valid_o,
    output logic [rv_decode_pkg::XLEN-1:0] dec_pc_o,
    output logic [4:0]                     rd_o,
    output logic [4:0]                     rs1_o,
    output logic [4:0]                     rs2_o,
    output logic                           reg_write_o,
    output rv_decode_pkg::result_src_t     result_src_o,
    output logic                           mem_write_o,
    output logic                           alu_src_o,
    output rv_decode_pkg::alu_ctrl_t       alu_ctrl_o,
    output logic                           branch_o,
    output logic                           jump_o,
    output logic [rv_decode_pkg::XLEN-1:0] imm_ext_o
);

    import rv_decode_pkg::*;

    instr_u          instr;
    logic            branch;
    logic            jump;
    result_src_t     result_src;
    logic            mem_write;
    logic            alu_src;
    imm_src_t        imm_src;
    logic            reg_write;
    alu_op_t         alu_op;
    alu_ctrl_t       alu_ctrl;
    logic [XLEN-1:0] imm_ext;

    assign pop_o = ~empty_i & ~hold_i;
    assign instr = instr_u'(pop_instr_i); // head word, valid while not empty

    main_decoder i_main_decoder (
        .op_i         (instr.r_fmt.opcode),
        .branch_o     (branch),
        .jump_o       (jump),
        .result_src_o (result_src),
        .mem_write_o  (mem_write),
        .alu_src_o    (alu_src),
        .imm_src_o    (imm_src),
        .reg_write_o  (reg_write),
        .alu_op_o     (alu_op)
    );

    alu_decoder i_alu_decoder (
        .alu_op_i   (alu_op),
        .funct3_i   (instr.r_fmt.funct3),
        .funct7b5_i (instr.r_fmt.funct7[5]),
        .op_b5_i    (instr.r_fmt.opcode[5]), // set for register ops only
        .alu_ctrl_o (alu_ctrl)
    );

    imm_extend i_imm_extend (
        .instr_i   (instr),
        .imm_src_i (imm_src),
        .imm_ext_o (imm_ext)
    );

    // control outputs, cleared by reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            reg_write_o <= 1'b0;
            mem_write_o <= 1'b0;
            branch_o    <= 1'b0;
            jump_o      <= 1'b0;
        end else begin
            dec_valid_o <= pop_o; // one pulse per popped word
            if (pop_o) begin
                reg_write_o <= reg_write;
                mem_write_o <= mem_write;
                branch_o    <= branch;
                jump_o      <= jump;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dec_pc_o     <= pop_pc_i;
            rd_o         <= instr.r_fmt.rd;
            rs1_o        <= instr.r_fmt.rs1;
            rs2_o        <= instr.r_fmt.rs2;
            result_src_o <= result_src;
            alu_src_o    <= alu_src;
            alu_ctrl_o   <= alu_ctrl;
            imm_ext_o    <= imm_ext;
        end
    end

endmodule

/* source/decode_top.sv */
`timescale 1ns/1ns

module decode_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           instr_valid_i,
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    input  logic                           hold_i,
    output logic                           fetch_ready_o,
    output logic [rv_decode_pkg::XLEN-1:0] fetch_pc_o,
    output logic                           dec_valid_o,
    output logic [rv_decode_pkg::XLEN-1:0] dec_pc_o,
    output logic [4:0]                     rd_o,
    output logic [4:0]                     rs1_o,
    output logic [4:0]                     rs2_o,
    output logic                           reg_write_o,
    output rv_decode_pkg::result_src_t     result_src_o,
    output logic                           mem_write_o,
    output logic                           alu_src_o,
    output rv_decode_pkg::alu_ctrl_t       alu_ctrl_o,
    output logic                           branch_o,
    output logic                           jump_o,
    output logic [rv_decode_pkg::XLEN-1:0] imm_ext_o
);

    import rv_decode_pkg::*;

    logic            push;
    logic [XLEN-1:0] push_pc;
    logic [XLEN-1:0] push_instr;
    logic            pop;
    logic [XLEN-1:0] pop_pc;
    logic [XLEN-1:0] pop_instr;
    logic            full;
    logic            empty;

    assign fetch_ready_o = ~full;

    fetch_unit i_fetch_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .full_i        (full),
        .push_o        (push),
        .push_pc_o     (push_pc),
        .push_instr_o  (push_instr),
        .fetch_pc_o    (fetch_pc_o)
    );

    instr_queue i_instr_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_pc_i    (push_pc),
        .push_instr_i (push_instr),
        .pop_i        (pop),
        .pop_pc_o     (pop_pc),
        .pop_instr_o  (pop_instr),
        .full_o       (full),
        .empty_o      (empty)
    );

    decode_stage i_decode_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .empty_i      (empty),
        .pop_pc_i     (pop_pc),
        .pop_instr_i  (pop_instr),
        .hold_i       (hold_i),
        .pop_o        (pop),
        .dec_valid_o  (dec_valid_o),
        .dec_pc_o     (dec_pc_o),
        .rd_o         (rd_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .reg_write_o  (reg_write_o),
        .result_src_o (result_src_o),
        .mem_write_o  (mem_write_o),
        .alu_src_o    (alu_src_o),
        .alu_ctrl_o   (alu_ctrl_o),
        .branch_o     (branch_o),
        .jump_o       (jump_o),
        .imm_ext_o    (imm_ext_o)
    );

endmodule

/* include/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// included inside a scope that imports rv_decode_pkg
typedef struct packed {
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    logic        alu_src;
    alu_ctrl_t   alu_ctrl;
    logic        branch;
    logic        jump;
    logic [31:0] imm_ext;
} dec_vec_t;

localparam int NUM_VECTORS = 15;

// word, rd, rs1, rs2, reg_write, result_src, mem_write, alu_src, alu_ctrl, branch, jump, imm
localparam dec_vec_t DEC_VECTORS [NUM_VECTORS] = '{
    '{32'hFFC12283, 5'd5,  5'd2,  5'd28, '1, RES_MEM, '0, '1, ALU_ADD,   '0, '0, 32'hFFFFFFFC},
    '{32'h0061A423, 5'd8,  5'd3,  5'd6,  '0, RES_ALU, '1, '1, ALU_ADD,   '0, '0, 32'h00000008},
    '{32'hFE712A23, 5'd20, 5'd2,  5'd7,  '0, RES_ALU, '1, '1, ALU_ADD,   '0, '0, 32'hFFFFFFF4},
    '{32'h003100B3, 5'd1,  5'd2,  5'd3,  '1, RES_ALU, '0, '0, ALU_ADD,   '0, '0, 32'h00000003},
    '{32'h40628233, 5'd4,  5'd5,  5'd6,  '1, RES_ALU, '0, '0, ALU_SUB,   '0, '0, 32'h00000406},
    '{32'h0041A133, 5'd2,  5'd3,  5'd4,  '1, RES_ALU, '0, '0, ALU_SLT,   '0, '0, 32'h00000004},
    '{32'hFE208CE3, 5'd25, 5'd1,  5'd2,  '0, RES_ALU, '0, '0, ALU_SUB,   '1, '0, 32'hFFFFFFF8},
    '{32'h00418863, 5'd16, 5'd3,  5'd4,  '0, RES_ALU, '0, '0, ALU_SUB,   '1, '0, 32'h00000010},
    '{32'h12300393, 5'd7,  5'd0,  5'd3,  '1, RES_ALU, '0, '1, ALU_ADD,   '0, '0, 32'h00000123},
    '{32'hFFF48413, 5'd8,  5'd9,  5'd31, '1, RES_ALU, '0, '1, ALU_ADD,   '0, '0, 32'hFFFFFFFF},
    '{32'h001000EF, 5'd1,  5'd0,  5'd1,  '1, RES_PC4, '0, '0, ALU_ADD,   '0, '1, 32'h00000800},
    '{32'hFFDFF06F, 5'd0,  5'd31, 5'd29, '1, RES_PC4, '0, '0, ALU_ADD,   '0, '1, 32'hFFFFFFFC},
    '{32'hABCDE537, 5'd10, 5'd27, 5'd28, '1, RES_ALU, '0, '1, ALU_PASSB, '0, '0, 32'hABCDE000},
    '{32'h12345637, 5'd12, 5'd8,  5'd3,  '1, RES_ALU, '0, '1, ALU_PASSB, '0, '0, 32'h12345000},
    '{32'h00B5057F, 5'd10, 5'd10, 5'd11, '1, RES_ALU, '0, '0, ALU_ADD,   '0, '0, 32'h0000000B}
};

`endif

/* dv/tb_decode_top.sv */
`timescale 1ns/1ns

module tb_decode_top;

    import rv_decode_pkg::*;

    `include "decode_vectors.svh"

    localparam int WAIT_LIMIT = 40; // cycles before any wait gives up

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    logic [XLEN-1:0]   instr;
    logic              hold;
    logic              fetch_ready;
    logic [XLEN-1:0]   fetch_pc;
    logic              dec_valid;
    logic [XLEN-1:0]   dec_pc;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic              reg_write;
    result_src_t       result_src;
    logic              mem_write;
    logic              alu_src;
    alu_ctrl_t         alu_ctrl;
    logic              branch;
    logic              jump;
    logic [XLEN-1:0]   imm_ext;

    int                exp_rows[$]; // table rows accepted but not yet decoded
    logic [XLEN-1:0]   exp_dec_pc;
    logic [XLEN-1:0]   exp_fetch_pc;

    decode_top i_decode_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .hold_i        (hold),
        .fetch_ready_o (fetch_ready),
        .fetch_pc_o    (fetch_pc),
        .dec_valid_o   (dec_valid),
        .dec_pc_o      (dec_pc),
        .rd_o          (rd),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .reg_write_o   (reg_write),
        .result_src_o  (result_src),
        .mem_write_o   (mem_write),
        .alu_src_o     (alu_src),
        .alu_ctrl_o    (alu_ctrl),
        .branch_o      (branch),
        .jump_o        (jump),
        .imm_ext_o     (imm_ext)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_result_src(input result_src_t got, input result_src_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH result_src_o got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_alu_ctrl(input alu_ctrl_t got, input alu_ctrl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH alu_ctrl_o got %h expected %h", got, exp));
        end
    endtask

    // inputs held from one falling edge to the next
    // row below zero marks a word outside the table
    task automatic drive_cycle(input logic valid, input logic [XLEN-1:0] word,
                               input logic hold_lvl, input int row, output bit accepted);
        compare_word("fetch_pc_o", fetch_pc, exp_fetch_pc);
        instr_valid = valid;
        instr       = word;
        hold        = hold_lvl;
        accepted    = valid && fetch_ready;
        if (accepted) begin
            exp_fetch_pc = exp_fetch_pc + XLEN'(4);
            if (row >= 0) exp_rows.push_back(row);
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        bit acc;
        cycles = 0;
        while (exp_rows.size() != 0) begin
            if (cycles == WAIT_LIMIT) abort_run("timeout waiting for the queue to drain");
            drive_cycle(1'b0, '0, 1'b0, -1, acc);
            cycles++;
        end
        drive_cycle(1'b0, '0, 1'b0, -1, acc); // settle one more cycle
    endtask

    task automatic send_row(input int row, input bit random_hold);
        int tries;
        bit acc;
        logic hold_lvl;
        tries = 0;
        acc   = 1'b0;
        while (!acc) begin
            if (tries == WAIT_LIMIT) abort_run("timeout waiting for fetch_ready_o");
            hold_lvl = random_hold ? (($urandom() % 3) == 0) : 1'b0;
            drive_cycle(fetch_ready, DEC_VECTORS[row].instr, hold_lvl, row, acc);
            tries++;
        end
    endtask

    // every result is checked against the oldest accepted row
    always @(negedge clk) begin : check_results
        dec_vec_t v;
        if (rst_n && dec_valid) begin
            if (exp_rows.size() == 0) begin
                abort_run("decode result with no accepted word outstanding");
            end else begin
                v = DEC_VECTORS[exp_rows.pop_front()];
                compare_word("dec_pc_o", dec_pc, exp_dec_pc);
                compare_reg("rd_o", rd, v.rd);
                compare_reg("rs1_o", rs1, v.rs1);
                compare_reg("rs2_o", rs2, v.rs2);
                compare_bit("reg_write_o", reg_write, v.reg_write);
                compare_result_src(result_src, v.result_src);
                compare_bit("mem_write_o", mem_write, v.mem_write);
                compare_bit("alu_src_o", alu_src, v.alu_src);
                compare_alu_ctrl(alu_ctrl, v.alu_ctrl);
                compare_bit("branch_o", branch, v.branch);
                compare_bit("jump_o", jump, v.jump);
                compare_word("imm_ext_o", imm_ext, v.imm_ext);
                exp_dec_pc = exp_dec_pc + XLEN'(4);
            end
        end
    end

    initial begin : stimulus
        int cycles;
        int filled;
        bit acc;
        void'($urandom(32'h74a9d7b9));
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        hold         = 1'b0;
        exp_dec_pc   = '0;
        exp_fetch_pc = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        compare_bit("dec_valid_o", dec_valid, 1'b0);
        compare_bit("fetch_ready_o", fetch_ready, 1'b1);
        compare_bit("reg_write_o", reg_write, 1'b0);
        compare_bit("mem_write_o", mem_write, 1'b0);
        compare_bit("branch_o", branch, 1'b0);
        compare_bit("jump_o", jump, 1'b0);

        // single word into an idle subsystem
        drive_cycle(1'b1, DEC_VECTORS[0].instr, 1'b0, 0, acc);
        cycles = 1;
        while (!dec_valid) begin
            if (cycles == WAIT_LIMIT) abort_run("timeout waiting for dec_valid_o");
            drive_cycle(1'b0, '0, 1'b0, -1, acc);
            cycles++;
        end
        if (cycles != 2) abort_run($sformatf("decode latency was %0d cycles, not 2", cycles));
        wait_drained();

        for (int r = 0; r < NUM_VECTORS; r++) send_row(r, 1'b0);
        wait_drained();

        // fill the queue behind a held decode stage
        filled = 0;
        while (fetch_ready && filled < QUEUE_DEPTH + 2) begin
            drive_cycle(1'b1, DEC_VECTORS[filled].instr, 1'b1, filled, acc);
            filled++;
        end
        if (filled != QUEUE_DEPTH) begin
            abort_run($sformatf("fetch_ready_o fell after %0d words, not 4", filled));
        end
        compare_bit("dec_valid_o", dec_valid, 1'b0);
        repeat (2) drive_cycle(1'b1, 32'h00000013, 1'b1, -1, acc); // dropped strobes
        wait_drained();

        for (int r = 0; r < NUM_VECTORS; r++) send_row(r, 1'b1);
        wait_drained();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
source/rv_decode_pkg.sv
source/fetch_unit.sv
source/instr_queue.sv
source/main_decoder.sv
source/alu_decoder.sv
source/imm_extend.sv
source/decode_stage.sv
source/decode_top.sv
dv/tb_decode_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f sim.f \
    --top-module tb_decode_top -o tb_decode_top_sim

./obj_dir/tb_decode_top_sim 2>&1 | tee sim.log || true

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
grep -q "NO ERRORS" sim.log
